// File: rtl/csr_defs_pkg.sv
// CSR address and access definitions
package csr_defs_pkg;

    parameter int XLEN = 32;

    // Supported CSR addresses
    typedef enum logic [11:0] {
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15,
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        MCYCLE     = 12'hB00,
        MINSTRET   = 12'hB02,
        MCYCLEH    = 12'hB80,
        MINSTRETH  = 12'hB82,
        CYCLE      = 12'hC00,     // User mode read aliases
        TIME       = 12'hC01,
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        TIMEH      = 12'hC81,
        INSTRETH   = 12'hC82
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_e;

    // Merged write toward the register owners
    typedef struct packed {
        logic            en;
        csr_addr_e       addr;
        logic [XLEN-1:0] data;
    } csr_wr_t;

    parameter logic [XLEN-1:0] MSTATUS_MASK = 32'h0000_1888;  // MPP, MPIE, MIE
    parameter logic [XLEN-1:0] MIE_MASK     = 32'h0000_0888;
    parameter logic [XLEN-1:0] MISA_MASK    = 32'h0030_1000;

    parameter int MSTATUS_MIE_BIT  = 3;
    parameter int MSTATUS_MPIE_BIT = 7;
    parameter int MSTATUS_MPP_LSB  = 11;

    parameter int IRQ_EXT_BIT = 11;
    parameter int IRQ_SW_BIT  = 3;
    parameter int IRQ_TIM_BIT = 7;

endpackage

// File: rtl/trap_pkg.sv
// Trap and privilege definitions
package trap_pkg;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 5'd0,
        INSTRUCTION_ACCESS_FAULT       = 5'd1,
        ILLEGAL_INSTRUCTION            = 5'd2,
        BREAKPOINT                     = 5'd3,
        LOAD_ADDRESS_MISALIGNED        = 5'd4,
        LOAD_ACCESS_FAULT              = 5'd5,
        STORE_ADDRESS_MISALIGNED       = 5'd6,
        STORE_ACCESS_FAULT             = 5'd7,
        ECALL_FROM_UMODE               = 5'd8,
        ECALL_FROM_MMODE               = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        NO_INT    = 5'd0,
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } int_code_e;

    // Trap requests from the pipeline
    typedef struct packed {
        logic        mret;
        logic        exception;
        exc_code_e   exc_code;
        logic        interrupt_ack;
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] instruction;
        logic        jump;
        logic [31:0] jump_target;
    } trap_event_t;

    typedef struct packed {
        logic        mstatus_mie;
        logic        mstatus_mpie;
        priv_e       mstatus_mpp;
        logic [31:0] misa;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mscratch;
        logic [31:0] mepc;
        logic [31:0] mtval;
        logic        mcause_int;
        logic [30:0] mcause_code;
    } trap_state_t;

endpackage

// File: rtl/csr_access.sv
// CSR access decode and merge
`timescale 1ns/1ps

module csr_access #(
    parameter bit COMPRESSED = 1'b0
) (
    input  logic                   csr_read_i,
    input  logic                   csr_write_i,
    input  csr_defs_pkg::csr_op_e  csr_op_i,
    input  logic [11:0]            csr_addr_i,
    input  logic [31:0]            csr_wdata_i,
    output logic [31:0]            csr_rdata_o,
    input  trap_pkg::trap_state_t  trap_state_i,
    input  logic [31:0]            mip_i,
    input  logic [63:0]            mcycle_i,
    input  logic [63:0]            minstret_i,
    input  logic [63:0]            mtime_i,
    output logic [31:0]            misa_value_o,
    output csr_defs_pkg::csr_wr_t  csr_wr_o
);
    import csr_defs_pkg::*;
    import trap_pkg::*;

    // Alignment mask for trap vector and return address
    localparam logic [XLEN-1:0] PC_MASK = COMPRESSED ? 32'hFFFF_FFFE : 32'hFFFF_FFFC;

    csr_addr_e       addr;
    logic [XLEN-1:0] mstatus, mcause;
    logic [XLEN-1:0] cur_val, wmask, merged;

    assign addr         = csr_addr_e'(csr_addr_i);
    assign misa_value_o = 32'h4010_1100 | {29'b0, COMPRESSED, 2'b0};  // RV32 I M U, C opt

    always_comb begin
        mstatus = '0;
        mstatus[MSTATUS_MIE_BIT]           = trap_state_i.mstatus_mie;
        mstatus[MSTATUS_MPIE_BIT]          = trap_state_i.mstatus_mpie;
        mstatus[MSTATUS_MPP_LSB +: 2]      = trap_state_i.mstatus_mpp;
    end

    assign mcause = {trap_state_i.mcause_int, trap_state_i.mcause_code};

    //////////////////////////////////////////////////
    // Current value and write mask
    always_comb begin
        case (addr)
            MSTATUS:   begin cur_val = mstatus;               wmask = MSTATUS_MASK; end
            MISA:      begin cur_val = trap_state_i.misa;     wmask = MISA_MASK;    end
            MIE:       begin cur_val = trap_state_i.mie;      wmask = MIE_MASK;     end
            MTVEC:     begin cur_val = trap_state_i.mtvec;    wmask = PC_MASK;      end
            MSCRATCH:  begin cur_val = trap_state_i.mscratch; wmask = '1;           end
            MEPC:      begin cur_val = trap_state_i.mepc;     wmask = PC_MASK;      end
            MCAUSE:    begin cur_val = mcause;                wmask = '1;           end
            MTVAL:     begin cur_val = trap_state_i.mtval;    wmask = '1;           end
            MCYCLE:    begin cur_val = mcycle_i[31:0];        wmask = '1;           end
            MCYCLEH:   begin cur_val = mcycle_i[63:32];       wmask = '1;           end
            MINSTRET:  begin cur_val = minstret_i[31:0];      wmask = '1;           end
            MINSTRETH: begin cur_val = minstret_i[63:32];     wmask = '1;           end
            default:   begin cur_val = '0;                    wmask = '0;           end
        endcase
    end

    always_comb begin
        case (csr_op_i)
            CSR_SET:   merged = cur_val | (csr_wdata_i & wmask);
            CSR_CLEAR: merged = cur_val & ~(csr_wdata_i & wmask);
            default:   merged = (cur_val & ~wmask) | (csr_wdata_i & wmask);
        endcase
    end

    assign csr_wr_o = '{en: csr_write_i, addr: addr, data: merged};

    //////////////////////////////////////////////////
    // Read port
    always_comb begin
        csr_rdata_o = '0;
        if (csr_read_i) begin
            case (addr)
                MSTATUS:            csr_rdata_o = mstatus;
                MIP:                csr_rdata_o = mip_i;
                MCYCLE, CYCLE:      csr_rdata_o = mcycle_i[31:0];
                MCYCLEH, CYCLEH:    csr_rdata_o = mcycle_i[63:32];
                MINSTRET, INSTRET:  csr_rdata_o = minstret_i[31:0];
                MINSTRETH, INSTRETH: csr_rdata_o = minstret_i[63:32];
                TIME:               csr_rdata_o = mtime_i[31:0];
                TIMEH:              csr_rdata_o = mtime_i[63:32];
                default:            csr_rdata_o = cur_val;  // ID regs and unknown give 0
            endcase
        end
    end

endmodule

// File: rtl/csr_trap_regs.sv
// Machine trap registers
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                   clk,
    input  logic                   reset_n,
    input  csr_defs_pkg::csr_wr_t  csr_wr_i,
    input  logic [31:0]            misa_value_i,
    input  trap_pkg::trap_event_t  trap_i,
    input  trap_pkg::int_code_e    int_code_i,
    output trap_pkg::trap_state_t  trap_state_o,
    output trap_pkg::priv_e        privilege_o
);
    import csr_defs_pkg::*;
    import trap_pkg::*;

    trap_state_t state;
    priv_e       privilege;

    assign trap_state_o = state;
    assign privilege_o  = privilege;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state             <= '0;
            state.mstatus_mpp <= PRIV_MACHINE;
            state.misa        <= misa_value_i;
            privilege         <= PRIV_MACHINE;
        end else begin
            //////////////////////////////////////////////////
            // Machine return
            if (trap_i.mret) begin
                state.mstatus_mie <= state.mstatus_mpie;
                privilege         <= state.mstatus_mpp;
            end
            //////////////////////////////////////////////////
            // Exception entry
            else if (trap_i.exception) begin
                state.mcause_int   <= 1'b0;
                state.mcause_code  <= 31'(trap_i.exc_code);
                state.mepc         <= trap_i.pc;
                state.mtval        <= (trap_i.exc_code == ILLEGAL_INSTRUCTION)
                                      ? trap_i.instruction
                                      : trap_i.pc;
                state.mstatus_mpie <= state.mstatus_mie;
                state.mstatus_mie  <= 1'b0;
                state.mstatus_mpp  <= privilege;
                privilege          <= PRIV_MACHINE;
            end
            //////////////////////////////////////////////////
            // Interrupt entry
            else if (trap_i.interrupt_ack) begin
                state.mcause_int   <= 1'b1;
                state.mcause_code  <= 31'(int_code_i);
                // Current instruction retires first, so return past it
                state.mepc         <= trap_i.jump ? trap_i.jump_target : trap_i.next_pc;
                state.mstatus_mpie <= state.mstatus_mie;
                state.mstatus_mie  <= 1'b0;
                state.mstatus_mpp  <= privilege;
                privilege          <= PRIV_MACHINE;
            end
            //////////////////////////////////////////////////
            // Software write
            else if (csr_wr_i.en) begin
                case (csr_wr_i.addr)
                    MSTATUS: begin
                        state.mstatus_mie  <= csr_wr_i.data[MSTATUS_MIE_BIT];
                        state.mstatus_mpie <= csr_wr_i.data[MSTATUS_MPIE_BIT];
                        state.mstatus_mpp  <= priv_e'(csr_wr_i.data[MSTATUS_MPP_LSB +: 2]);
                    end
                    MISA:     state.misa     <= csr_wr_i.data;
                    MIE:      state.mie      <= csr_wr_i.data;
                    MTVEC:    state.mtvec    <= csr_wr_i.data;
                    MSCRATCH: state.mscratch <= csr_wr_i.data;
                    MEPC:     state.mepc     <= csr_wr_i.data;
                    MTVAL:    state.mtval    <= csr_wr_i.data;
                    MCAUSE: begin
                        state.mcause_int  <= csr_wr_i.data[XLEN-1];
                        state.mcause_code <= csr_wr_i.data[XLEN-2:0];
                    end
                    default: ;  // Held elsewhere or not implemented
                endcase
            end
        end
    end

endmodule

// File: rtl/csr_counters.sv
// Cycle and retired instruction counters
`timescale 1ns/1ps

module csr_counters (
    input  logic                   clk,
    input  logic                   reset_n,
    input  csr_defs_pkg::csr_wr_t  csr_wr_i,
    input  logic                   retire_i,
    output logic [63:0]            mcycle_o,
    output logic [63:0]            minstret_o
);
    import csr_defs_pkg::*;

    // Written half replaces the count for that cycle
    function automatic logic [63:0] next_count(input logic [63:0] cur, input logic inc,
                                               input csr_wr_t wr, input csr_addr_e lo,
                                               input csr_addr_e hi);
        logic [63:0] nxt;
        nxt = cur + 64'(inc);
        if (wr.en && wr.addr == lo)
            nxt = {cur[63:XLEN], wr.data};
        else if (wr.en && wr.addr == hi)
            nxt = {wr.data, cur[XLEN-1:0]};
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
        end else begin
            mcycle_o   <= next_count(mcycle_o, 1'b1, csr_wr_i, MCYCLE, MCYCLEH);
            minstret_o <= next_count(minstret_o, retire_i, csr_wr_i, MINSTRET, MINSTRETH);
        end
    end

endmodule

// File: rtl/irq_ctrl.sv
// Machine interrupt controller
`timescale 1ns/1ps

module irq_ctrl (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [31:0]            irq_i,
    input  trap_pkg::trap_state_t  trap_state_i,
    input  logic                   interrupt_ack_i,
    output logic [31:0]            mip_o,
    output logic                   interrupt_pending_o,
    output trap_pkg::int_code_e    int_code_o
);
    import csr_defs_pkg::*;
    import trap_pkg::*;

    logic [31:0] active;  // Enabled and pending lines

    assign active = trap_state_i.mie & mip_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_o               <= '0;
            interrupt_pending_o <= 1'b0;
            int_code_o          <= NO_INT;
        end else begin
            mip_o               <= irq_i;
            interrupt_pending_o <= trap_state_i.mstatus_mie && (active != '0) && !interrupt_ack_i;
            if (trap_state_i.mstatus_mie && !interrupt_ack_i) begin
                if (active[IRQ_EXT_BIT])       int_code_o <= M_EXT_INT;
                else if (active[IRQ_SW_BIT])   int_code_o <= M_SW_INT;
                else if (active[IRQ_TIM_BIT])  int_code_o <= M_TIM_INT;
            end
        end
    end

endmodule

// File: rtl/csr_bank_top.sv
// CSR bank top level
`timescale 1ns/1ps

module csr_bank_top #(
    parameter bit COMPRESSED = 1'b0
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   csr_read_i,
    input  logic                   csr_write_i,
    input  csr_defs_pkg::csr_op_e  csr_op_i,
    input  logic [11:0]            csr_addr_i,
    input  logic [31:0]            csr_wdata_i,
    output logic [31:0]            csr_rdata_o,
    input  trap_pkg::trap_event_t  trap_i,
    input  logic                   retire_i,
    input  logic [63:0]            mtime_i,
    input  logic [31:0]            irq_i,
    output logic                   interrupt_pending_o,
    output trap_pkg::priv_e        privilege_o,
    output logic [31:0]            mepc_o,
    output logic [31:0]            mtvec_o
);
    import csr_defs_pkg::*;
    import trap_pkg::*;

    csr_wr_t     csr_wr;
    trap_state_t trap_state;
    int_code_e   int_code;
    logic [31:0] misa_value, mip;
    logic [63:0] mcycle, minstret;

    assign mepc_o  = trap_state.mepc;   // Return address for the fetch unit
    assign mtvec_o = trap_state.mtvec;

    csr_access #(.COMPRESSED(COMPRESSED)) u_access (
        .csr_read_i, .csr_write_i, .csr_op_i, .csr_addr_i, .csr_wdata_i, .csr_rdata_o,
        .trap_state_i(trap_state), .mip_i(mip), .mcycle_i(mcycle),
        .minstret_i(minstret), .mtime_i, .misa_value_o(misa_value), .csr_wr_o(csr_wr)
    );

    csr_trap_regs u_trap_regs (
        .clk, .reset_n, .csr_wr_i(csr_wr), .misa_value_i(misa_value), .trap_i,
        .int_code_i(int_code), .trap_state_o(trap_state), .privilege_o
    );

    csr_counters u_counters (
        .clk, .reset_n, .csr_wr_i(csr_wr), .retire_i,
        .mcycle_o(mcycle), .minstret_o(minstret)
    );

    irq_ctrl u_irq (
        .clk, .reset_n, .irq_i, .trap_state_i(trap_state),
        .interrupt_ack_i(trap_i.interrupt_ack), .mip_o(mip),
        .interrupt_pending_o, .int_code_o(int_code)
    );

endmodule

// File: bench/csr_bank_chk.sv
// Interrupt controller assertions
`timescale 1ns/1ps

module csr_bank_chk (
    input logic                clk,
    input logic                reset_n,
    input logic                ack_i,
    input logic                mie_i,
    input logic                pending_i,
    input trap_pkg::int_code_e code_i
);
    import trap_pkg::*;

    ack_drops_pending: assert property (@(posedge clk) disable iff (!reset_n)
        ack_i |=> !pending_i)
        else $error("interrupt pending still high after acknowledge");

    // Global enable gates the registered flag
    mie_gates_pending: assert property (@(posedge clk) disable iff (!reset_n)
        !mie_i |=> !pending_i)
        else $error("interrupt pending high with mstatus.MIE clear");

    pending_cause_valid: assert property (@(posedge clk) disable iff (!reset_n)
        pending_i |-> code_i inside {M_SW_INT, M_TIM_INT, M_EXT_INT})
        else $error("pending interrupt carries an unknown cause code");

endmodule

bind irq_ctrl csr_bank_chk u_chk (
    .clk(clk), .reset_n(reset_n), .ack_i(interrupt_ack_i),
    .mie_i(trap_state_i.mstatus_mie), .pending_i(interrupt_pending_o), .code_i(int_code_o)
);

// File: bench/csr_bank_tb.sv
// CSR bank testbench
`timescale 1ns/1ps

module csr_bank_tb;
    import csr_defs_pkg::*;
    import trap_pkg::*;

    localparam int N_RESET  = 8;
    localparam int N_ACCESS = 16;
    // Two cycles per table row plus margin for the trap and counter tests
    localparam int CYCLE_LIMIT = 2 * (N_RESET + N_ACCESS) + 200;
    localparam logic [31:0] MISA_RESET = 32'h4010_1100;  // RV32 with I, M and U

    typedef struct packed {
        logic        wr;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
    } row_t;

    logic        clk, reset_n;
    logic        csr_read_i, csr_write_i;
    csr_op_e     csr_op_i;
    logic [11:0] csr_addr_i;
    logic [31:0] csr_wdata_i, csr_rdata_o;
    trap_event_t trap_i;
    logic        retire_i;
    logic [63:0] mtime_i;
    logic [31:0] irq_i;
    logic        interrupt_pending_o;
    priv_e       privilege_o;
    logic [31:0] mepc_o, mtvec_o;

    row_t        reset_tbl  [N_RESET];
    row_t        access_tbl [N_ACCESS];
    logic [11:0] reset_addrs [N_RESET] = '{MISA, MVENDORID, MARCHID, MIMPID, MHARTID,
                                           MCONFIGPTR, 12'h7C0, 12'h000};
    csr_addr_e   regs   [4] = '{MSCRATCH, MIE, MTVEC, MSTATUS};
    logic [31:0] masks  [4] = '{32'hFFFF_FFFF, 32'h0000_0888, 32'hFFFF_FFFC, 32'h0000_1888};
    logic [31:0] shadow [4] = '{32'h0, 32'h0, 32'h0, 32'h0000_1800};  // MPP machine at reset
    csr_op_e     ops    [3] = '{CSR_WRITE, CSR_SET, CSR_CLEAR};
    integer      seed = 88054;
    int          cycle_count = 0;

    csr_bank_top #(.COMPRESSED(1'b0)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    //////////////////////////////////////////////////
    // Reference rules
    function automatic logic [31:0] merge_expect(input csr_op_e op, input logic [31:0] cur,
                                                 input logic [31:0] data,
                                                 input logic [31:0] mask);
        case (op)
            CSR_SET:   return cur | (data & mask);
            CSR_CLEAR: return cur & ~(data & mask);
            default:   return (cur & ~mask) | (data & mask);
        endcase
    endfunction

    function automatic logic [31:0] mstatus_bits(input logic mie, input logic mpie,
                                                 input logic [1:0] mpp);
        return {19'b0, mpp, 3'b0, mpie, 3'b0, mie, 3'b0};
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Bus drivers
    task automatic write_csr(input csr_op_e op, input logic [11:0] addr, input logic [31:0] data);
        @(negedge clk);
        csr_write_i = 1'b1;
        csr_read_i  = 1'b0;
        csr_op_i    = op;
        csr_addr_i  = addr;
        csr_wdata_i = data;
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic rd, output logic [31:0] data);
        @(negedge clk);
        csr_write_i = 1'b0;
        csr_read_i  = rd;
        csr_addr_i  = addr;
        #1 data = csr_rdata_o;  // Combinational read
    endtask

    task automatic send_trap(input trap_event_t ev);
        @(negedge clk);
        csr_write_i = 1'b0;
        csr_read_i  = 1'b0;
        trap_i      = ev;
        @(negedge clk);
        trap_i      = '0;
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] got;
        if (r.wr)
            write_csr(r.op, r.addr, r.data);
        read_csr(r.addr, 1'b1, got);
        compare($sformatf("csr_rdata_o[0x%03h]", r.addr), got, r.exp_val);
    endtask

    initial begin
        trap_event_t ev;
        logic [31:0] got, prev, pc, insn, target, hi;
        int          waited;
        int          k;

        reset_n     = 1'b0;
        csr_read_i  = 1'b0;
        csr_write_i = 1'b0;
        csr_op_i    = CSR_WRITE;
        csr_addr_i  = '0;
        csr_wdata_i = '0;
        trap_i      = '0;
        retire_i    = 1'b0;
        irq_i       = '0;
        mtime_i     = {$random(seed), $random(seed)};

        foreach (reset_tbl[i]) begin
            reset_tbl[i]         = '0;
            reset_tbl[i].addr    = reset_addrs[i];
            reset_tbl[i].exp_val = (i == 0) ? MISA_RESET : 32'h0;
        end
        for (int i = 0; i < N_ACCESS; i++) begin
            k = i % 4;
            access_tbl[i].wr   = 1'b1;
            access_tbl[i].op   = ops[(i / 4) % 3];
            access_tbl[i].addr = regs[k];
            access_tbl[i].data = $random(seed);
            shadow[k] = merge_expect(access_tbl[i].op, shadow[k], access_tbl[i].data, masks[k]);
            access_tbl[i].exp_val = shadow[k];
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        foreach (reset_tbl[i]) apply_row(reset_tbl[i]);
        foreach (access_tbl[i]) apply_row(access_tbl[i]);

        read_csr(MSCRATCH, 1'b0, got);
        compare("csr_rdata_o with read low", got, 32'h0);
        write_csr(CSR_WRITE, 12'h7C0, $random(seed));
        for (int i = 0; i < 4; i++) begin
            read_csr(regs[i], 1'b1, got);
            compare("csr_rdata_o after unknown write", got, shadow[i]);
        end
        compare("mtvec_o", mtvec_o, shadow[2]);

        //////////////////////////////////////////////////
        // Exception entry and machine return
        write_csr(CSR_WRITE, MSTATUS, mstatus_bits(1'b0, 1'b1, PRIV_USER));
        ev      = '0;
        ev.mret = 1'b1;
        send_trap(ev);
        compare("privilege_o", 32'(privilege_o), 32'(PRIV_USER));
        read_csr(MSTATUS, 1'b1, got);
        compare("mstatus after mret", got, mstatus_bits(1'b1, 1'b1, PRIV_USER));

        pc             = $random(seed);
        insn           = $random(seed);
        ev             = '0;
        ev.exception   = 1'b1;
        ev.exc_code    = ILLEGAL_INSTRUCTION;
        ev.pc          = pc;
        ev.instruction = insn;
        send_trap(ev);
        compare("privilege_o", 32'(privilege_o), 32'(PRIV_MACHINE));
        compare("mepc_o", mepc_o, pc);
        read_csr(MCAUSE, 1'b1, got);
        compare("mcause", got, 32'd2);
        read_csr(MTVAL, 1'b1, got);
        compare("mtval", got, insn);
        read_csr(MSTATUS, 1'b1, got);
        compare("mstatus after exception", got, mstatus_bits(1'b0, 1'b1, PRIV_USER));

        ev      = '0;
        ev.mret = 1'b1;
        send_trap(ev);
        compare("privilege_o", 32'(privilege_o), 32'(PRIV_USER));
        read_csr(MSTATUS, 1'b1, got);
        compare("mstatus after mret", got, mstatus_bits(1'b1, 1'b1, PRIV_USER));

        pc             = $random(seed);  // Load fault reports pc in mtval
        ev             = '0;
        ev.exception   = 1'b1;
        ev.exc_code    = LOAD_ACCESS_FAULT;
        ev.pc          = pc;
        ev.instruction = insn;
        send_trap(ev);
        read_csr(MCAUSE, 1'b1, got);
        compare("mcause", got, 32'd5);
        read_csr(MTVAL, 1'b1, got);
        compare("mtval", got, pc);

        //////////////////////////////////////////////////
        // Interrupt request and acknowledge
        write_csr(CSR_WRITE, MSTATUS, mstatus_bits(1'b1, 1'b0, PRIV_MACHINE));
        write_csr(CSR_WRITE, MIE, 32'h0000_0888);
        @(negedge clk);
        csr_write_i = 1'b0;
        irq_i       = (32'd1 << 11) | (32'd1 << 7);  // External and timer
        waited      = 0;
        while (!interrupt_pending_o && waited < 2) begin
            @(negedge clk);
            waited++;
        end
        if (!interrupt_pending_o) begin
            $display("Interrupt pending did not rise within two cycles of the request");
            $display("TEST FAIL");
            $fatal(1, "missing interrupt");
        end
        target           = $random(seed);
        ev               = '0;
        ev.interrupt_ack = 1'b1;
        ev.jump          = 1'b1;
        ev.jump_target   = target;
        ev.next_pc       = target ^ 32'h10;
        send_trap(ev);
        irq_i = '0;
        compare("interrupt_pending_o", 32'(interrupt_pending_o), 32'd0);
        compare("mepc_o", mepc_o, target);
        read_csr(MCAUSE, 1'b1, got);
        compare("mcause", got, 32'h8000_000B);

        //////////////////////////////////////////////////
        // Counters and user aliases
        read_csr(MCYCLE, 1'b1, prev);
        repeat (9) @(negedge clk);
        read_csr(MCYCLE, 1'b1, got);
        compare("mcycle delta", got - prev, 32'd10);

        read_csr(MINSTRET, 1'b1, prev);
        repeat (5) begin
            @(negedge clk);
            retire_i = 1'b1;
            @(negedge clk);
            retire_i = 1'b0;
        end
        read_csr(MINSTRET, 1'b1, got);
        compare("minstret delta", got - prev, 32'd5);
        read_csr(INSTRET, 1'b1, prev);
        compare("instret", prev, 32'd5);  // Only retires since reset

        hi = $random(seed);
        write_csr(CSR_WRITE, MCYCLEH, hi);
        read_csr(MCYCLEH, 1'b1, got);
        compare("mcycleh", got, hi);
        read_csr(CYCLEH, 1'b1, got);
        compare("cycleh", got, hi);
        read_csr(MCYCLE, 1'b1, prev);
        read_csr(CYCLE, 1'b1, got);
        compare("cycle", got, prev + 32'd1);
        read_csr(TIME, 1'b1, got);
        compare("time", got, mtime_i[31:0]);
        read_csr(TIMEH, 1'b1, got);
        compare("timeh", got, mtime_i[63:32]);

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: filelist.f
rtl/csr_defs_pkg.sv
rtl/trap_pkg.sv
rtl/csr_access.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/irq_ctrl.sv
rtl/csr_bank_top.sv
bench/csr_bank_chk.sv
bench/csr_bank_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module csr_bank_tb -Mdir obj_dir

run: compile
	./obj_dir/Vcsr_bank_tb | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
